// ==== arch_regfile.sv ====
// architectural register file, written at retire, two combinational read ports
`default_nettype none
`timescale 1ns/100ps

module arch_regfile (
    input  wire logic              clock,
    input  wire logic              rst_n,

    input  wire logic              write_en,
    input  wire isa_pkg::reg_idx_t write_idx,
    input  wire isa_pkg::word_t    write_value,

    input  wire isa_pkg::reg_idx_t read_idx1,
    input  wire isa_pkg::reg_idx_t read_idx2,
    output isa_pkg::word_t         read_value1,
    output isa_pkg::word_t         read_value2
);

    isa_pkg::word_t regs [isa_pkg::NUM_REGS];

    // x0 reads as zero whatever is stored
    assign read_value1 = (read_idx1 == isa_pkg::ZERO_REG) ? '0 : regs[read_idx1];
    assign read_value2 = (read_idx2 == isa_pkg::ZERO_REG) ? '0 : regs[read_idx2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_idx != isa_pkg::ZERO_REG)) begin
            regs[write_idx] <= write_value;
        end
    end

endmodule

`default_nettype wire

// ==== isa_pkg.sv ====
// architectural constants and word/register types, referenced by scoped name
`default_nettype none

package isa_pkg;

    // data path width
    localparam int XLEN = 32;

    // data word or program counter
    typedef logic [XLEN-1:0] word_t;

    // architectural register file size
    localparam int NUM_REGS  = 32;
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    // architectural register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // x0, hardwired to zero, never renamed
    localparam reg_idx_t ZERO_REG = '0;

    // sequential pc step
    localparam word_t INST_BYTES = 4;

endpackage

`default_nettype wire

// ==== map_table.sv ====
// rename table: architectural register to in-flight reorder buffer tag
`default_nettype none
`timescale 1ns/100ps

module map_table #(
    parameter int rob_size = rob_pkg::ROB_SIZE_DEFAULT,
    localparam int tag_w = $clog2(rob_size)
) (
    input  wire logic              clock,
    input  wire logic              rst_n,

    input  wire logic              alloc,
    input  wire logic [tag_w-1:0]  alloc_tag,
    input  wire isa_pkg::reg_idx_t dispatch_dest,

    input  wire logic              retire_write,
    input  wire isa_pkg::reg_idx_t retire_dest,
    input  wire logic [tag_w-1:0]  head_tag,
    input  wire logic              squash,

    input  wire isa_pkg::reg_idx_t src1,
    input  wire isa_pkg::reg_idx_t src2,
    output logic                   src1_busy,
    output logic [tag_w-1:0]       src1_tag,
    output logic                   src2_busy,
    output logic [tag_w-1:0]       src2_tag
);

    logic             busy [isa_pkg::NUM_REGS];
    logic [tag_w-1:0] tags [isa_pkg::NUM_REGS];

    logic rename;
    logic release_ok;

    assign rename = alloc && (dispatch_dest != isa_pkg::ZERO_REG);

    // only the youngest producer may free the mapping
    assign release_ok = retire_write &&
                        (tags[retire_dest] == head_tag) &&
                        !(rename && (dispatch_dest == retire_dest));

    // lookup sees the map before this cycle's rename
    assign src1_busy = busy[src1];
    assign src1_tag  = tags[src1];
    assign src2_busy = busy[src2];
    assign src2_tag  = tags[src2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                busy[i] <= 1'b0;
                tags[i] <= '0;
            end
        end else if (squash) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                busy[i] <= 1'b0;
            end
        end else begin
            if (release_ok) begin
                busy[retire_dest] <= 1'b0;
            end
            if (rename) begin
                busy[dispatch_dest] <= 1'b1;
                tags[dispatch_dest] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rob.sv ====
// circular reorder buffer: dispatch at tail, cdb completion, in-order retire and squash
`default_nettype none
`timescale 1ns/100ps

module rob #(
    parameter int rob_size = rob_pkg::ROB_SIZE_DEFAULT,
    localparam int tag_w = $clog2(rob_size)
) (
    input  wire logic              clock,
    input  wire logic              rst_n,

    // dispatch side
    input  wire logic              dispatch_valid,
    input  wire isa_pkg::word_t    dispatch_pc,
    input  wire isa_pkg::reg_idx_t dispatch_dest,
    input  wire logic              dispatch_store,
    input  wire logic              dispatch_taken,
    input  wire logic              dispatch_halt,

    // completion bus
    input  wire logic              cdb_valid,
    input  wire logic [tag_w-1:0]  cdb_tag,
    input  wire isa_pkg::word_t    cdb_value,
    input  wire logic              cdb_taken,

    // store queue acknowledge level
    input  wire logic              store_ack,

    // operand read ports
    input  wire logic [tag_w-1:0]  rd_tag1,
    input  wire logic [tag_w-1:0]  rd_tag2,
    output logic                   rd_ready1,
    output logic                   rd_ready2,
    output isa_pkg::word_t         rd_value1,
    output isa_pkg::word_t         rd_value2,

    output logic                   rob_full,
    output logic                   alloc,
    output logic [tag_w-1:0]       alloc_tag,
    output logic [tag_w-1:0]       head_tag,

    // retire side
    output logic                   retire_valid,
    output logic                   retire_write,
    output isa_pkg::reg_idx_t      retire_dest,
    output isa_pkg::word_t         retire_value,
    output isa_pkg::word_t         retire_next_pc,

    output logic                   store_commit,
    output logic                   squash,
    output isa_pkg::word_t         target_pc,
    output logic                   halt
);

    rob_pkg::rob_entry_t entries [rob_size];

    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    // one extra bit so a full buffer is distinguishable from empty
    logic [tag_w:0]   count;

    rob_pkg::rob_entry_t head_entry;

    //////////////////////////////////////////////////////////////////////
    // combinational status and retire decision
    //////////////////////////////////////////////////////////////////////

    assign head_entry = entries[head];

    assign rob_full  = (count == (tag_w + 1)'(rob_size));
    assign alloc     = dispatch_valid && !rob_full;
    assign alloc_tag = tail;
    assign head_tag  = head;

    // halt goes without completion, stores wait for the queue
    assign retire_valid = head_entry.valid &&
                          ((head_entry.ready && (!head_entry.store || store_ack)) ||
                           head_entry.halt);

    assign retire_write   = retire_valid && (head_entry.dest != isa_pkg::ZERO_REG);
    assign retire_dest    = head_entry.dest;
    assign retire_value   = head_entry.value;
    assign retire_next_pc = head_entry.pc + isa_pkg::INST_BYTES;

    assign store_commit = retire_valid && head_entry.store;
    assign halt         = retire_valid && head_entry.halt;
    assign squash       = retire_valid && head_entry.mispred;

    // predicted taken means the fall-through path was the right one
    assign target_pc = head_entry.taken ? retire_next_pc : head_entry.value;

    // operand lookup by tag
    assign rd_ready1 = entries[rd_tag1].ready;
    assign rd_ready2 = entries[rd_tag2].ready;
    assign rd_value1 = entries[rd_tag1].value;
    assign rd_value2 = entries[rd_tag2].value;

    //////////////////////////////////////////////////////////////////////
    // entry array, pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i] <= '0;
            end
        end else if (squash) begin
            // whole window is on the wrong path
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i] <= '0;
            end
        end else begin
            // completion, ignored for freed slots
            if (cdb_valid && entries[cdb_tag].valid) begin
                entries[cdb_tag].ready   <= 1'b1;
                entries[cdb_tag].value   <= cdb_value;
                entries[cdb_tag].mispred <= (cdb_taken != entries[cdb_tag].taken);
            end

            if (retire_valid) begin
                entries[head] <= '0;
                head <= (head == tag_w'(rob_size - 1)) ? '0 : head + 1'b1;
            end

            if (alloc) begin
                entries[tail].valid   <= 1'b1;
                entries[tail].ready   <= 1'b0;
                entries[tail].store   <= dispatch_store;
                entries[tail].taken   <= dispatch_taken;
                entries[tail].mispred <= 1'b0;
                entries[tail].halt    <= dispatch_halt;
                entries[tail].pc      <= dispatch_pc;
                entries[tail].dest    <= dispatch_dest;
                entries[tail].value   <= '0;
                tail <= (tail == tag_w'(rob_size - 1)) ? '0 : tail + 1'b1;
            end

            // occupancy holds when one goes in and one goes out
            case ({alloc, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rob_core.f ====
isa_pkg.sv
rob_pkg.sv
rob.sv
map_table.sv
arch_regfile.sv
rob_core.sv
tb_clock_gen.sv
rob_core_chk.sv
rob_core_tb.sv

// ==== rob_core.sv ====
// commit top level, joins reorder buffer, rename table and register file
`default_nettype none
`timescale 1ns/100ps

module rob_core #(
    parameter int rob_size = rob_pkg::ROB_SIZE_DEFAULT,
    localparam int tag_w = $clog2(rob_size)
) (
    input  wire logic              clock,
    input  wire logic              rst_n,

    input  wire logic              dispatch_valid,
    input  wire isa_pkg::word_t    dispatch_pc,
    input  wire isa_pkg::reg_idx_t dispatch_dest,
    input  wire isa_pkg::reg_idx_t dispatch_src1,
    input  wire isa_pkg::reg_idx_t dispatch_src2,
    input  wire logic              dispatch_store,
    input  wire logic              dispatch_taken,
    input  wire logic              dispatch_halt,

    input  wire logic              cdb_valid,
    input  wire logic [tag_w-1:0]  cdb_tag,
    input  wire isa_pkg::word_t    cdb_value,
    input  wire logic              cdb_taken,

    input  wire logic              store_ack,

    output logic                   rob_full,
    output logic [tag_w-1:0]       dispatch_tag,

    output logic                   src1_busy,
    output logic [tag_w-1:0]       src1_tag,
    output logic                   src1_ready,
    output isa_pkg::word_t         src1_rob_value,
    output isa_pkg::word_t         src1_reg_value,
    output logic                   src2_busy,
    output logic [tag_w-1:0]       src2_tag,
    output logic                   src2_ready,
    output isa_pkg::word_t         src2_rob_value,
    output isa_pkg::word_t         src2_reg_value,

    output logic                   retire_valid,
    output isa_pkg::reg_idx_t      retire_dest,
    output isa_pkg::word_t         retire_value,
    output isa_pkg::word_t         retire_next_pc,

    output logic                   store_commit,
    output logic                   squash,
    output isa_pkg::word_t         target_pc,
    output logic                   halt
);

    logic             alloc;
    logic             retire_write;
    logic [tag_w-1:0] head_tag;

    //////////////////////////////////////////////////////////////////////
    // reorder buffer, read ports indexed by the renamed source tags
    //////////////////////////////////////////////////////////////////////

    rob #(
        .rob_size (rob_size)
    ) rob_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_pc    (dispatch_pc),
        .dispatch_dest  (dispatch_dest),
        .dispatch_store (dispatch_store),
        .dispatch_taken (dispatch_taken),
        .dispatch_halt  (dispatch_halt),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cdb_taken      (cdb_taken),
        .store_ack      (store_ack),
        .rd_tag1        (src1_tag),
        .rd_tag2        (src2_tag),
        .rd_ready1      (src1_ready),
        .rd_ready2      (src2_ready),
        .rd_value1      (src1_rob_value),
        .rd_value2      (src2_rob_value),
        .rob_full       (rob_full),
        .alloc          (alloc),
        .alloc_tag      (dispatch_tag),
        .head_tag       (head_tag),
        .retire_valid   (retire_valid),
        .retire_write   (retire_write),
        .retire_dest    (retire_dest),
        .retire_value   (retire_value),
        .retire_next_pc (retire_next_pc),
        .store_commit   (store_commit),
        .squash         (squash),
        .target_pc      (target_pc),
        .halt           (halt)
    );

    map_table #(
        .rob_size (rob_size)
    ) map_table_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .alloc         (alloc),
        .alloc_tag     (dispatch_tag),
        .dispatch_dest (dispatch_dest),
        .retire_write  (retire_write),
        .retire_dest   (retire_dest),
        .head_tag      (head_tag),
        .squash        (squash),
        .src1          (dispatch_src1),
        .src2          (dispatch_src2),
        .src1_busy     (src1_busy),
        .src1_tag      (src1_tag),
        .src2_busy     (src2_busy),
        .src2_tag      (src2_tag)
    );

    // committed state
    arch_regfile arch_regfile_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .write_en    (retire_write),
        .write_idx   (retire_dest),
        .write_value (retire_value),
        .read_idx1   (dispatch_src1),
        .read_idx2   (dispatch_src2),
        .read_value1 (src1_reg_value),
        .read_value2 (src2_reg_value)
    );

endmodule

`default_nettype wire

// ==== rob_core_chk.sv ====
// protocol assertions on the reorder buffer, bound into every rob instance
`default_nettype none
`timescale 1ns/100ps

module rob_core_chk (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic dispatch_valid,
    input wire logic rob_full,
    input wire logic retire_valid,
    input wire logic squash,
    input wire logic store_commit,
    input wire logic store_ack,
    input wire logic halt
);

    // window is empty right after a squash
    squash_clears_window: assert property (@(posedge clock) disable iff (!rst_n)
        squash |=> !retire_valid && !rob_full) else $error("buffer not empty after squash");

    commit_needs_ack: assert property (@(posedge clock) disable iff (!rst_n)
        store_commit |-> store_ack) else $error("store commit without ack");

    // an accepted dispatch while full would wrap the occupancy
    full_holds_without_retire: assert property (@(posedge clock) disable iff (!rst_n)
        rob_full && dispatch_valid && !retire_valid |=> rob_full)
        else $error("dispatch accepted while full");

    // control outputs quiet while reset is held
    quiet_in_reset: assert property (@(posedge clock)
        !rst_n |-> !(retire_valid || store_commit || squash || halt || rob_full))
        else $error("control output active in reset");

endmodule

bind rob rob_core_chk rob_core_chk_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .rob_full       (rob_full),
    .retire_valid   (retire_valid),
    .squash         (squash),
    .store_commit   (store_commit),
    .store_ack      (store_ack),
    .halt           (halt)
);

`default_nettype wire

// ==== rob_core_tb.sv ====
// table-driven testbench for rob_core, one row per clock cycle with a small tag model
`default_nettype none
`timescale 1ns/100ps

module rob_core_tb;

    typedef struct {
        // dispatch
        bit                dv;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t dest;
        isa_pkg::reg_idx_t src1;
        bit                st;
        bit                tk;
        bit                hl;
        // completion and store queue
        bit                cv;
        bit [1:0]          ctag;
        bit                ctk;
        bit                ack;
        // expected
        bit                full;
        bit                ret;
        bit [1:0]          rtag;
        bit                sq;
        bit                sc;
        bit                hlt;
        bit                busy;
        bit                rdy;
    } row_t;

    logic clock, rst_n;
    logic dispatch_valid, dispatch_store, dispatch_taken, dispatch_halt;
    isa_pkg::word_t dispatch_pc, cdb_value;
    isa_pkg::reg_idx_t dispatch_dest, dispatch_src1, dispatch_src2;
    logic cdb_valid, cdb_taken, store_ack;
    logic [1:0] cdb_tag;
    logic rob_full, src1_busy, src1_ready, src2_busy, src2_ready;
    logic [1:0] dispatch_tag, src1_tag, src2_tag;
    isa_pkg::word_t src1_rob_value, src1_reg_value, src2_rob_value, src2_reg_value;
    logic retire_valid, store_commit, squash, halt;
    isa_pkg::reg_idx_t retire_dest;
    isa_pkg::word_t retire_value, retire_next_pc, target_pc;

    row_t rows[$];
    integer seed = 32'hf4763110;
    // tag model of the buffer
    isa_pkg::word_t m_pc[4], m_val[4], m_regs[32];
    isa_pkg::reg_idx_t m_dest[4];
    bit m_tk[4];
    bit m_rdy[4];
    logic [1:0] m_map[32];
    bit m_busy[32];
    int tail = 0;
    // second source follows the latest renamed register
    isa_pkg::reg_idx_t last_dest = '0;

    tb_clock_gen tb_clock_gen_i (.clock(clock), .rst_n(rst_n));

    rob_core #(.rob_size(4)) rob_core_i (.*);

    task automatic report_error(string what);
        $display("** Error at %0t ns: %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_word(string what, isa_pkg::word_t got, isa_pkg::word_t exp);
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_reg(string what, isa_pkg::reg_idx_t got, isa_pkg::reg_idx_t exp);
        if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_tag(string what, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic add_row(bit dv, isa_pkg::word_t pc, isa_pkg::reg_idx_t dest,
                           isa_pkg::reg_idx_t src1, bit st, bit tk, bit hl, bit cv,
                           bit [1:0] ctag, bit ctk, bit ack, bit full, bit ret,
                           bit [1:0] rtag, bit sq, bit sc, bit hlt, bit busy, bit rdy);
        row_t r;
        r = '{dv, pc, dest, src1, st, tk, hl, cv, ctag, ctk, ack,
              full, ret, rtag, sq, sc, hlt, busy, rdy};
        rows.push_back(r);
    endtask

    // retire expectation from the tag model
    task automatic check_retire(bit [1:0] t, bit sq);
        check_reg("retire_dest", retire_dest, m_dest[t]);
        check_word("retire_value", retire_value, m_val[t]);
        check_word("retire_next_pc", retire_next_pc, m_pc[t] + 32'd4);
        if (sq) begin
            check_word("target_pc", target_pc, m_tk[t] ? m_pc[t] + 32'd4 : m_val[t]);
        end
    endtask

    // second lookup port against the rename model
    task automatic check_src2(isa_pkg::reg_idx_t s);
        check_bit("src2_busy", src2_busy, m_busy[s]);
        check_word("src2_reg_value", src2_reg_value, m_regs[s]);
        if (m_busy[s]) begin
            check_tag("src2_tag", src2_tag, m_map[s]);
            check_bit("src2_ready", src2_ready, m_rdy[m_map[s]]);
            if (m_rdy[m_map[s]]) begin
                check_word("src2_rob_value", src2_rob_value, m_val[m_map[s]]);
            end
        end
    endtask

    task automatic apply_row(row_t r);
        isa_pkg::reg_idx_t src2;
        isa_pkg::reg_idx_t rd;
        bit                accept;
        src2   = last_dest;
        accept = r.dv && !r.full;
        @(posedge clock);
        #1;
        dispatch_valid = r.dv;
        dispatch_pc    = r.pc;
        dispatch_dest  = r.dest;
        dispatch_src1  = r.src1;
        dispatch_src2  = src2;
        dispatch_store = r.st;
        dispatch_taken = r.tk;
        dispatch_halt  = r.hl;
        cdb_valid      = r.cv;
        cdb_tag        = r.ctag;
        cdb_taken      = r.ctk;
        cdb_value      = r.cv ? $random(seed) : '0;
        store_ack      = r.ack;
        #6;
        check_bit("rob_full", rob_full, r.full);
        check_bit("retire_valid", retire_valid, r.ret);
        check_bit("squash", squash, r.sq);
        check_bit("store_commit", store_commit, r.sc);
        check_bit("halt", halt, r.hlt);
        check_bit("src1_busy", src1_busy, r.busy);
        check_word("src1_reg_value", src1_reg_value, m_regs[r.src1]);
        if (r.busy) begin
            check_tag("src1_tag", src1_tag, m_map[r.src1]);
            check_bit("src1_ready", src1_ready, r.rdy);
            if (r.rdy) check_word("src1_rob_value", src1_rob_value, m_val[m_map[r.src1]]);
        end
        check_src2(src2);
        if (accept) check_tag("dispatch_tag", dispatch_tag, tail[1:0]);
        if (r.ret) begin
            check_retire(r.rtag, r.sq);
            rd = m_dest[r.rtag];
            if (rd != 0) begin
                m_regs[rd] = m_val[r.rtag];
                // a rename in the same cycle keeps the register busy
                if (m_map[rd] == r.rtag && !(accept && r.dest == rd)) begin
                    m_busy[rd] = 1'b0;
                end
            end
            m_rdy[r.rtag] = 1'b0;
        end
        if (r.cv) begin
            m_val[r.ctag] = cdb_value;
            m_rdy[r.ctag] = 1'b1;
        end
        if (r.sq) begin
            tail = 0;
            foreach (m_busy[k]) m_busy[k] = 1'b0;
            foreach (m_rdy[k]) m_rdy[k] = 1'b0;
        end else if (accept) begin
            m_pc[tail] = r.pc;
            m_dest[tail] = r.dest;
            m_tk[tail] = r.tk;
            m_val[tail] = '0;
            m_rdy[tail] = 1'b0;
            if (r.dest != 0) begin
                m_map[r.dest] = tail[1:0];
                m_busy[r.dest] = 1'b1;
                last_dest = r.dest;
            end
            tail = (tail + 1) % 4;
        end
    endtask

    initial begin
        int i;
        {dispatch_valid, dispatch_store, dispatch_taken, dispatch_halt} = '0;
        {dispatch_pc, dispatch_dest, dispatch_src1, dispatch_src2} = '0;
        {cdb_valid, cdb_tag, cdb_value, cdb_taken, store_ack} = '0;
        foreach (m_regs[k]) m_regs[k] = '0;
        foreach (m_map[k]) m_map[k] = '0;
        // in-order retire of reverse completions
        add_row(1,'h100,1,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h104,2,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h108,3,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,2,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,1,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,1,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,1,1,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,1,2,0,0,0, 0,0);
        // renaming of x5, then x0 destination
        add_row(1,'h10c,5,5,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,5,0,0,0, 1,3,0,0, 0,0,0,0,0,0, 1,0);
        add_row(0,0,0,5,0,0,0, 0,0,0,0, 0,1,3,0,0,0, 1,1);
        add_row(0,0,0,5,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h110,0,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,1,0,0,0,0, 0,0);
        // fill, drop the fifth, drain
        add_row(1,'h200,6,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h204,7,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h208,8,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h20c,9,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h210,10,0,0,0,0, 0,0,0,0, 1,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,1,0,0, 1,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,2,0,0, 1,1,1,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,3,0,0, 0,1,2,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,0,0,0, 0,1,3,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,1,0,0,0,0, 0,0);
        // not-taken prediction resolved taken
        add_row(1,'h300,0,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h304,11,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,11,0,0,0, 1,1,1,0, 0,0,0,0,0,0, 1,0);
        add_row(0,0,0,11,0,0,0, 0,0,0,0, 0,1,1,1,0,0, 1,0);
        // taken prediction resolved not-taken
        add_row(1,'h400,11,11,0,1,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,11,0,0,0, 1,0,0,0, 0,0,0,0,0,0, 1,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,1,0,1,0,0, 0,0);
        // store held until the queue acknowledges
        add_row(1,'h500,0,11,1,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 1,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,1, 0,1,0,0,1,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,1, 0,0,0,0,0,0, 0,0);
        // halt behind two ops
        add_row(1,'h600,12,0,0,0,0, 0,0,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h604,13,0,0,0,0, 1,1,0,0, 0,0,0,0,0,0, 0,0);
        add_row(1,'h608,0,0,0,0,1, 1,2,0,0, 0,1,1,0,0,0, 0,0);
        add_row(0,0,0,0,0,0,0, 0,0,0,0, 0,1,2,0,0,0, 0,0);

        for (i = 0; i < 50 && rst_n !== 1'b1; i++) @(posedge clock);
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            $display("RESULT: FAIL");
            $fatal(1, "reset timeout");
        end else begin
            foreach (rows[k]) apply_row(rows[k]);

            @(posedge clock);
            #1;
            {dispatch_valid, dispatch_halt, cdb_valid, store_ack} = '0;
            #6;
            for (i = 0; i < 20 && !halt; i++) begin
                @(posedge clock);
                #7;
            end
            if (!halt) begin
                $display("halt never retired");
                $display("RESULT: FAIL");
                $fatal(1, "halt timeout");
            end else begin
                check_bit("retire_valid", retire_valid, 1'b1);
                check_retire(2'd3, 1'b0);
                $display("RESULT: PASS");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rob_pkg.sv ====
// reorder buffer depth default and entry layout, referenced by scoped name
`default_nettype none

package rob_pkg;

    // depth used by the core unless overridden at the top
    localparam int ROB_SIZE_DEFAULT = 16;

    // one in-flight instruction
    typedef struct packed {
        logic              valid;
        // result has come back on the cdb
        logic              ready;
        logic              store;
        // predicted direction from fetch
        logic              taken;
        // set at completion when outcome differs from prediction
        logic              mispred;
        logic              halt;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t dest;
        // result, or branch target for a branch
        isa_pkg::word_t    value;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== tb_clock_gen.sv ====
// testbench clock and reset source, 8 ns period with reset held low for 8 cycles
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
